//--- fetch_types_pkg.sv
package fetch_types_pkg;

  // data and address width of the core
  localparam int XLEN = 32;

  // instruction words held by one cache line
  localparam int LINE_WORDS = 4;
  localparam int LINE_BITS = LINE_WORDS * 32;

  // byte offset bits inside a line and word select bits inside a line
  localparam int OFFSET_BITS = $clog2(LINE_WORDS * 4);
  localparam int WORD_BITS = $clog2(LINE_WORDS);

  typedef logic [XLEN-1:0] addr_t;
  typedef logic [31:0] inst_t;

  // word 0 of the line sits in the low bits
  typedef logic [LINE_BITS-1:0] line_t;

  // fetcher miss handling
  typedef enum logic [1:0] {
    FETCH_IDLE = 2'd0,
    FETCH_MISS = 2'd1
  } fetch_state_e;

endpackage

//--- rv_isa_pkg.sv
package rv_isa_pkg;

  // RV32I major opcodes, bits [6:0] of the instruction
  localparam int OPCODE_W = 7;
  localparam logic [OPCODE_W-1:0] MAJ_LUI = 7'b0110111;
  localparam logic [OPCODE_W-1:0] MAJ_AUIPC = 7'b0010111;
  localparam logic [OPCODE_W-1:0] MAJ_JAL = 7'b1101111;
  localparam logic [OPCODE_W-1:0] MAJ_JALR = 7'b1100111;
  localparam logic [OPCODE_W-1:0] MAJ_BRANCH = 7'b1100011;
  localparam logic [OPCODE_W-1:0] MAJ_LOAD = 7'b0000011;
  localparam logic [OPCODE_W-1:0] MAJ_STORE = 7'b0100011;
  localparam logic [OPCODE_W-1:0] MAJ_OP_IMM = 7'b0010011;
  localparam logic [OPCODE_W-1:0] MAJ_OP = 7'b0110011;

  typedef enum logic [3:0] {
    OPC_LUI = 4'd0,
    OPC_AUIPC = 4'd1,
    OPC_JAL = 4'd2,
    OPC_JALR = 4'd3,
    OPC_BRANCH = 4'd4,
    OPC_LOAD = 4'd5,
    OPC_STORE = 4'd6,
    OPC_OP_IMM = 4'd7,
    OPC_OP = 4'd8,
    OPC_ILLEGAL = 4'd9
  } opcode_e;

  // register field positions
  localparam int REG_W = 5;
  localparam int RD_LSB = 7;
  localparam int RS1_LSB = 15;
  localparam int RS2_LSB = 20;

  // every immediate format takes its sign from here
  localparam int IMM_SIGN_BIT = 31;

  function automatic logic [31:0] imm_i(input logic [31:0] inst);
    return {{20{inst[IMM_SIGN_BIT]}}, inst[31:20]};
  endfunction

  function automatic logic [31:0] imm_s(input logic [31:0] inst);
    return {{20{inst[IMM_SIGN_BIT]}}, inst[31:25], inst[11:7]};
  endfunction

  function automatic logic [31:0] imm_b(input logic [31:0] inst);
    return {{20{inst[IMM_SIGN_BIT]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
  endfunction

  function automatic logic [31:0] imm_u(input logic [31:0] inst);
    return {inst[31:12], 12'b0};
  endfunction

  function automatic logic [31:0] imm_j(input logic [31:0] inst);
    return {{12{inst[IMM_SIGN_BIT]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
  endfunction

endpackage

//--- inst_fetcher.sv
`timescale 1ns/1ps

module inst_fetcher
  import fetch_types_pkg::*;
#(
  parameter int CACHE_LINES = 8
) (
  input  logic  clk,
  input  logic  reset_from_rob_bus,
  input  logic  is_any_full,
  input  logic  redirect_valid,
  input  addr_t redirect_pc,
  output logic  mem_req,
  output addr_t mem_addr,
  input  logic  mem_fill,
  input  line_t mem_line,
  input  addr_t pred_next_pc,
  output logic  fetch_hit,
  output logic  fetch_take,
  output addr_t fetch_pc,
  output inst_t fetch_inst,
  output addr_t fetch_next_pc
);

  localparam int INDEX_BITS = $clog2(CACHE_LINES);
  localparam int TAG_BITS = XLEN - INDEX_BITS - OFFSET_BITS;

  // direct-mapped cache arrays
  logic [TAG_BITS-1:0] tag_mem [CACHE_LINES];
  line_t line_mem [CACHE_LINES];
  logic [CACHE_LINES-1:0] valid_bits;

  fetch_state_e state;
  addr_t pc;

  logic [TAG_BITS-1:0] pc_tag;
  logic [INDEX_BITS-1:0] pc_index;
  logic [WORD_BITS-1:0] pc_word;
  addr_t pc_line_addr;
  logic hit;
  logic fill_write;

  assign pc_tag = pc[XLEN-1 -: TAG_BITS];
  assign pc_index = pc[OFFSET_BITS +: INDEX_BITS];
  assign pc_word = pc[OFFSET_BITS-1:2];
  assign pc_line_addr = {pc[XLEN-1:OFFSET_BITS], {OFFSET_BITS{1'b0}}};

  assign hit = valid_bits[pc_index] && (tag_mem[pc_index] == pc_tag);

  // fill lands only if the pc still sits in the requested line
  assign fill_write = (state == FETCH_MISS) && mem_fill && (pc_line_addr == mem_addr);

  assign fetch_hit = hit;
  assign fetch_take = hit && !is_any_full;
  assign fetch_pc = pc;
  assign fetch_inst = hit ? line_mem[pc_index][pc_word * 32 +: 32] : '0;
  assign fetch_next_pc = pred_next_pc;

  // redirect wins over the predicted path
  always_ff @(posedge clk) begin
    if (reset_from_rob_bus) begin
      pc <= '0;
    end else if (redirect_valid) begin
      pc <= redirect_pc;
    end else if (fetch_take) begin
      pc <= pred_next_pc;
    end
  end

  always_ff @(posedge clk) begin
    if (reset_from_rob_bus) begin
      state <= FETCH_IDLE;
      mem_req <= 1'b0;
      mem_addr <= '0;
      valid_bits <= '0;
    end else begin
      case (state)
        FETCH_IDLE: begin
          if (!hit && !redirect_valid) begin
            mem_req <= 1'b1;
            mem_addr <= pc_line_addr;
            state <= FETCH_MISS;
          end
        end
        FETCH_MISS: begin
          if (mem_fill) begin
            mem_req <= 1'b0;
            state <= FETCH_IDLE;
          end
          if (fill_write) begin
            valid_bits[pc_index] <= 1'b1;
          end
        end
        default: begin
          state <= FETCH_IDLE;
          mem_req <= 1'b0;
        end
      endcase
    end
  end

  // tag and line storage
  always_ff @(posedge clk) begin
    if (fill_write) begin
      tag_mem[pc_index] <= pc_tag;
      line_mem[pc_index] <= mem_line;
    end
  end

endmodule

//--- line_mem_ctrl.sv
`timescale 1ns/1ps

module line_mem_ctrl
  import fetch_types_pkg::*;
#(
  parameter int MEM_LINES = 64,
  parameter int MEM_LATENCY = 3
) (
  input  logic  clk,
  input  logic  reset_from_rob_bus,
  input  logic  prog_we,
  input  addr_t prog_addr,
  input  inst_t prog_data,
  input  logic  mem_req,
  input  addr_t mem_addr,
  output logic  mem_fill,
  output line_t mem_line
);

  localparam int LINE_ADDR_BITS = $clog2(MEM_LINES);
  localparam int CNT_BITS = $clog2(MEM_LATENCY + 1);

  // MC_HOLD waits for the request to drop after a fill
  typedef enum logic [1:0] {
    MC_IDLE = 2'd0,
    MC_COUNT = 2'd1,
    MC_HOLD = 2'd2
  } mc_state_e;

  line_t lines [MEM_LINES];

  mc_state_e state;
  logic [CNT_BITS-1:0] cnt;
  logic [LINE_ADDR_BITS-1:0] req_line;
  logic [LINE_ADDR_BITS-1:0] prog_line;
  logic [WORD_BITS-1:0] prog_word;

  assign prog_line = prog_addr[OFFSET_BITS +: LINE_ADDR_BITS];
  assign prog_word = prog_addr[OFFSET_BITS-1:2];

  // program load, one word at a time
  always_ff @(posedge clk) begin
    if (prog_we) begin
      lines[prog_line][prog_word * 32 +: 32] <= prog_data;
    end
  end

  always_ff @(posedge clk) begin
    if (reset_from_rob_bus) begin
      state <= MC_IDLE;
      cnt <= '0;
    end else begin
      case (state)
        MC_IDLE: begin
          if (mem_req) begin
            cnt <= CNT_BITS'(MEM_LATENCY - 1);
            state <= MC_COUNT;
          end
        end
        MC_COUNT: begin
          if (cnt == '0) begin
            state <= MC_HOLD;
          end else begin
            cnt <= cnt - 1'b1;
          end
        end
        MC_HOLD: begin
          if (!mem_req) begin
            state <= MC_IDLE;
          end
        end
        default: state <= MC_IDLE;
      endcase
    end
  end

  // line address is latched with the request
  always_ff @(posedge clk) begin
    if (state == MC_IDLE && mem_req) begin
      req_line <= mem_addr[OFFSET_BITS +: LINE_ADDR_BITS];
    end
  end

  assign mem_fill = (state == MC_COUNT) && (cnt == '0);
  assign mem_line = lines[req_line];

endmodule

//--- br_predictor.sv
`timescale 1ns/1ps

module br_predictor
  import fetch_types_pkg::*;
  import rv_isa_pkg::*;
(
  input  addr_t fetch_pc,
  input  inst_t fetch_inst,
  output addr_t pred_next_pc
);

  logic [OPCODE_W-1:0] major;
  addr_t seq_pc;
  addr_t jal_target;
  addr_t br_target;
  logic backward;

  assign major = fetch_inst[OPCODE_W-1:0];
  assign seq_pc = fetch_pc + 32'd4;
  assign jal_target = fetch_pc + imm_j(fetch_inst);
  assign br_target = fetch_pc + imm_b(fetch_inst);

  // a negative branch offset usually closes a loop
  assign backward = fetch_inst[IMM_SIGN_BIT];

  // static rule, jalr falls through since its target needs a register
  always_comb begin
    if (major == MAJ_JAL) begin
      pred_next_pc = jal_target;
    end else if (major == MAJ_BRANCH && backward) begin
      pred_next_pc = br_target;
    end else begin
      pred_next_pc = seq_pc;
    end
  end

endmodule

//--- inst_decoder.sv
`timescale 1ns/1ps

module inst_decoder
  import fetch_types_pkg::*;
  import rv_isa_pkg::*;
(
  input  logic           clk,
  input  logic           reset_from_rob_bus,
  input  logic           redirect_valid,
  input  logic           fetch_take,
  input  addr_t          fetch_pc,
  input  addr_t          fetch_next_pc,
  input  inst_t          fetch_inst,
  output logic           issue_valid,
  output addr_t          issue_pc,
  output addr_t          issue_next_pc,
  output inst_t          issue_inst,
  output opcode_e        issue_opcode,
  output logic [REG_W-1:0] issue_rd,
  output logic [REG_W-1:0] issue_rs1,
  output logic [REG_W-1:0] issue_rs2,
  output addr_t          issue_imm
);

  logic [REG_W-1:0] raw_rd;
  logic [REG_W-1:0] raw_rs1;
  logic [REG_W-1:0] raw_rs2;

  // a redirect kills the word sampled in the same cycle
  always_ff @(posedge clk) begin
    if (reset_from_rob_bus) begin
      issue_valid <= 1'b0;
    end else begin
      issue_valid <= fetch_take && !redirect_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (fetch_take) begin
      issue_pc <= fetch_pc;
      issue_next_pc <= fetch_next_pc;
      issue_inst <= fetch_inst;
    end
  end

  assign raw_rd = issue_inst[RD_LSB +: REG_W];
  assign raw_rs1 = issue_inst[RS1_LSB +: REG_W];
  assign raw_rs2 = issue_inst[RS2_LSB +: REG_W];

  // fields absent from a format read as zero
  always_comb begin
    issue_opcode = OPC_ILLEGAL;
    issue_rd = '0;
    issue_rs1 = '0;
    issue_rs2 = '0;
    issue_imm = '0;
    case (issue_inst[OPCODE_W-1:0])
      MAJ_LUI: begin
        issue_opcode = OPC_LUI;
        issue_rd = raw_rd;
        issue_imm = imm_u(issue_inst);
      end
      MAJ_AUIPC: begin
        issue_opcode = OPC_AUIPC;
        issue_rd = raw_rd;
        issue_imm = imm_u(issue_inst);
      end
      MAJ_JAL: begin
        issue_opcode = OPC_JAL;
        issue_rd = raw_rd;
        issue_imm = imm_j(issue_inst);
      end
      MAJ_JALR: begin
        issue_opcode = OPC_JALR;
        issue_rd = raw_rd;
        issue_rs1 = raw_rs1;
        issue_imm = imm_i(issue_inst);
      end
      MAJ_BRANCH: begin
        issue_opcode = OPC_BRANCH;
        issue_rs1 = raw_rs1;
        issue_rs2 = raw_rs2;
        issue_imm = imm_b(issue_inst);
      end
      MAJ_LOAD: begin
        issue_opcode = OPC_LOAD;
        issue_rd = raw_rd;
        issue_rs1 = raw_rs1;
        issue_imm = imm_i(issue_inst);
      end
      MAJ_STORE: begin
        issue_opcode = OPC_STORE;
        issue_rs1 = raw_rs1;
        issue_rs2 = raw_rs2;
        issue_imm = imm_s(issue_inst);
      end
      MAJ_OP_IMM: begin
        issue_opcode = OPC_OP_IMM;
        issue_rd = raw_rd;
        issue_rs1 = raw_rs1;
        issue_imm = imm_i(issue_inst);
      end
      MAJ_OP: begin
        issue_opcode = OPC_OP;
        issue_rd = raw_rd;
        issue_rs1 = raw_rs1;
        issue_rs2 = raw_rs2;
      end
      default: issue_opcode = OPC_ILLEGAL;
    endcase
  end

endmodule

//--- fetch_unit_top.sv
`timescale 1ns/1ps

module fetch_unit_top
  import fetch_types_pkg::*;
  import rv_isa_pkg::*;
#(
  parameter int CACHE_LINES = 8,
  parameter int MEM_LINES = 64,
  parameter int MEM_LATENCY = 3
) (
  input  logic           clk,
  input  logic           reset_from_rob_bus,
  input  logic           is_any_full,
  input  logic           redirect_valid,
  input  addr_t          redirect_pc,
  input  logic           prog_we,
  input  addr_t          prog_addr,
  input  inst_t          prog_data,
  output logic           issue_valid,
  output addr_t          issue_pc,
  output addr_t          issue_next_pc,
  output inst_t          issue_inst,
  output opcode_e        issue_opcode,
  output logic [REG_W-1:0] issue_rd,
  output logic [REG_W-1:0] issue_rs1,
  output logic [REG_W-1:0] issue_rs2,
  output addr_t          issue_imm
);

  logic  mem_req;
  addr_t mem_addr;
  logic  mem_fill;
  line_t mem_line;
  logic  fetch_hit;
  logic  fetch_take;
  addr_t fetch_pc;
  inst_t fetch_inst;
  addr_t fetch_next_pc;
  addr_t pred_next_pc;

  inst_fetcher #(
    .CACHE_LINES(CACHE_LINES)
  ) u_fetcher (
    .clk(clk),
    .reset_from_rob_bus(reset_from_rob_bus),
    .is_any_full(is_any_full),
    .redirect_valid(redirect_valid),
    .redirect_pc(redirect_pc),
    .mem_req(mem_req),
    .mem_addr(mem_addr),
    .mem_fill(mem_fill),
    .mem_line(mem_line),
    .pred_next_pc(pred_next_pc),
    .fetch_hit(fetch_hit),
    .fetch_take(fetch_take),
    .fetch_pc(fetch_pc),
    .fetch_inst(fetch_inst),
    .fetch_next_pc(fetch_next_pc)
  );

  line_mem_ctrl #(
    .MEM_LINES(MEM_LINES),
    .MEM_LATENCY(MEM_LATENCY)
  ) u_mem_ctrl (
    .clk(clk),
    .reset_from_rob_bus(reset_from_rob_bus),
    .prog_we(prog_we),
    .prog_addr(prog_addr),
    .prog_data(prog_data),
    .mem_req(mem_req),
    .mem_addr(mem_addr),
    .mem_fill(mem_fill),
    .mem_line(mem_line)
  );

  br_predictor u_predictor (
    .fetch_pc(fetch_pc),
    .fetch_inst(fetch_inst),
    .pred_next_pc(pred_next_pc)
  );

  inst_decoder u_decoder (
    .clk(clk),
    .reset_from_rob_bus(reset_from_rob_bus),
    .redirect_valid(redirect_valid),
    .fetch_take(fetch_take),
    .fetch_pc(fetch_pc),
    .fetch_next_pc(fetch_next_pc),
    .fetch_inst(fetch_inst),
    .issue_valid(issue_valid),
    .issue_pc(issue_pc),
    .issue_next_pc(issue_next_pc),
    .issue_inst(issue_inst),
    .issue_opcode(issue_opcode),
    .issue_rd(issue_rd),
    .issue_rs1(issue_rs1),
    .issue_rs2(issue_rs2),
    .issue_imm(issue_imm)
  );

endmodule

//--- fetch_unit_assertions.sv
`timescale 1ns/1ps

module fetch_unit_assertions
  import fetch_types_pkg::*;
(
  input logic  clk,
  input logic  reset_from_rob_bus,
  input logic  redirect_valid,
  input logic  mem_req,
  input logic  mem_fill,
  input logic  fetch_hit,
  input logic  fetch_take,
  input addr_t fetch_pc,
  input addr_t fetch_next_pc
);

  // failures so far, summed into the closing line
  int fail_count = 0;

  reset_clears_req: assert property (
    @(posedge clk) reset_from_rob_bus |=> !mem_req && !mem_fill
  ) else begin
    fail_count++;
    $error("mem_req or mem_fill high right after reset");
  end

  // a line request is held until its fill comes back
  req_held_until_fill: assert property (
    @(posedge clk) disable iff (reset_from_rob_bus)
    mem_req && !mem_fill |=> mem_req
  ) else begin
    fail_count++;
    $error("mem_req dropped before mem_fill");
  end

  fill_needs_req: assert property (
    @(posedge clk) disable iff (reset_from_rob_bus)
    mem_fill |-> mem_req
  ) else begin
    fail_count++;
    $error("mem_fill seen without mem_req");
  end

  // an idle miss with no redirect starts a line request
  miss_raises_req: assert property (
    @(posedge clk) disable iff (reset_from_rob_bus)
    !fetch_hit && !mem_req && !redirect_valid |=> mem_req
  ) else begin
    fail_count++;
    $error("mem_req did not rise on a cache miss");
  end

  // an accepted word moves the pc to its predicted successor
  take_advances_pc: assert property (
    @(posedge clk) disable iff (reset_from_rob_bus)
    fetch_take && !redirect_valid |=> fetch_pc == $past(fetch_next_pc)
  ) else begin
    fail_count++;
    $error("fetch_pc did not follow fetch_next_pc after a take");
  end

endmodule

bind inst_fetcher fetch_unit_assertions u_assertions (
  .clk(clk),
  .reset_from_rob_bus(reset_from_rob_bus),
  .redirect_valid(redirect_valid),
  .mem_req(mem_req),
  .mem_fill(mem_fill),
  .fetch_hit(fetch_hit),
  .fetch_take(fetch_take),
  .fetch_pc(fetch_pc),
  .fetch_next_pc(fetch_next_pc)
);

//--- tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen #(
  parameter int PERIOD_NS = 4,
  parameter int RESET_CYCLES = 8
) (
  input  logic load_busy,
  output logic clk,
  output logic reset_from_rob_bus
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD_NS / 2) clk = ~clk;
  end

  // reset spans the program load, then RESET_CYCLES more edges
  initial begin
    reset_from_rob_bus = 1'b1;
    @(negedge clk);
    wait (!load_busy);
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    reset_from_rob_bus = 1'b0;
  end

endmodule

//--- fetch_unit_tb.sv
`timescale 1ns/1ps

module fetch_unit_tb
  import fetch_types_pkg::*;
  import rv_isa_pkg::*;
;

  localparam int CACHE_LINES = 8;
  localparam int MEM_LINES = 64;
  localparam int MEM_LATENCY = 3;
  localparam int PROG_ROWS = 14;
  localparam int NUM_STEPS = 15;
  localparam int TIMEOUT_CYCLES = 40 * NUM_STEPS + 200;

  localparam logic [1:0] FULL_NONE = 2'd0;
  localparam logic [1:0] FULL_ALWAYS = 2'd1;
  localparam logic [1:0] FULL_RANDOM = 2'd2;

  typedef struct packed {
    addr_t   addr;
    inst_t   inst;
    opcode_e opc;
  } prog_row_t;

  // a step ends once both minimums are met
  typedef struct packed {
    logic [1:0] full_mode;
    logic       redirect;
    addr_t      target;
    logic [7:0] min_cycles;
    logic [7:0] min_issues;
  } step_t;

  // 0x00 and 0x80 share cache index 0
  prog_row_t prog_table [PROG_ROWS] = '{
    '{32'h00, 32'h00500093, OPC_OP_IMM},  // addi x1, x0, 5
    '{32'h04, 32'h12345137, OPC_LUI},     // lui x2, 0x12345
    '{32'h08, 32'hfffff197, OPC_AUIPC},   // auipc x3, 0xfffff
    '{32'h0c, 32'h00208233, OPC_OP},      // add x4, x1, x2
    '{32'h10, 32'hff80a283, OPC_LOAD},    // lw x5, -8(x1)
    '{32'h14, 32'h00512623, OPC_STORE},   // sw x5, 12(x2)
    '{32'h18, 32'h00208863, OPC_BRANCH},  // beq forward, falls through
    '{32'h1c, 32'hffffffff, OPC_ILLEGAL},
    '{32'h20, 32'hffc302e7, OPC_JALR},    // jalr x5, -4(x6)
    '{32'h24, 32'h05c000ef, OPC_JAL},     // jal x1, 0x80
    '{32'h40, 32'h0000000b, OPC_ILLEGAL}, // custom-0 code
    '{32'h44, 32'h03c0006f, OPC_JAL},     // jal x0, 0x80
    '{32'h80, 32'hfff30313, OPC_OP_IMM},  // addi x6, x6, -1
    '{32'h84, 32'hf6034ee3, OPC_BRANCH}   // blt backward to 0x00
  };

  step_t step_table [NUM_STEPS] = '{
    '{FULL_NONE,   1'b0, 32'h00, 8'd1,  8'd10},
    '{FULL_NONE,   1'b0, 32'h00, 8'd1,  8'd6},
    '{FULL_ALWAYS, 1'b0, 32'h00, 8'd12, 8'd0},
    '{FULL_NONE,   1'b0, 32'h00, 8'd1,  8'd4},
    '{FULL_RANDOM, 1'b0, 32'h00, 8'd1,  8'd12},
    '{FULL_NONE,   1'b1, 32'h40, 8'd2,  8'd0},
    '{FULL_NONE,   1'b1, 32'h14, 8'd1,  8'd6},
    '{FULL_RANDOM, 1'b1, 32'h84, 8'd1,  8'd5},
    '{FULL_ALWAYS, 1'b1, 32'h24, 8'd6,  8'd0},
    '{FULL_NONE,   1'b0, 32'h00, 8'd1,  8'd6},
    '{FULL_RANDOM, 1'b1, 32'h40, 8'd1,  8'd8},
    '{FULL_RANDOM, 1'b0, 32'h00, 8'd1,  8'd16},
    '{FULL_NONE,   1'b1, 32'h00, 8'd1,  8'd6},
    '{FULL_ALWAYS, 1'b0, 32'h00, 8'd8,  8'd0},
    '{FULL_RANDOM, 1'b0, 32'h00, 8'd1,  8'd10}
  };

  logic clk;
  logic reset_from_rob_bus;
  logic load_busy;
  logic is_any_full;
  logic redirect_valid;
  addr_t redirect_pc;
  logic prog_we;
  addr_t prog_addr;
  inst_t prog_data;
  logic issue_valid;
  addr_t issue_pc;
  addr_t issue_next_pc;
  inst_t issue_inst;
  opcode_e issue_opcode;
  logic [REG_W-1:0] issue_rd;
  logic [REG_W-1:0] issue_rs1;
  logic [REG_W-1:0] issue_rs2;
  addr_t issue_imm;

  // scoreboard state
  addr_t exp_pc;
  logic prev_full;
  logic prev_redirect;
  int cycle_idx;
  int cycle_count;
  int issued_total;
  int value_errors;
  int run_errors;

  tb_clock_gen #(
    .PERIOD_NS(4),
    .RESET_CYCLES(8)
  ) u_clock_gen (
    .load_busy(load_busy),
    .clk(clk),
    .reset_from_rob_bus(reset_from_rob_bus)
  );

  fetch_unit_top #(
    .CACHE_LINES(CACHE_LINES),
    .MEM_LINES(MEM_LINES),
    .MEM_LATENCY(MEM_LATENCY)
  ) u_fetch_unit_top (
    .clk(clk),
    .reset_from_rob_bus(reset_from_rob_bus),
    .is_any_full(is_any_full),
    .redirect_valid(redirect_valid),
    .redirect_pc(redirect_pc),
    .prog_we(prog_we),
    .prog_addr(prog_addr),
    .prog_data(prog_data),
    .issue_valid(issue_valid),
    .issue_pc(issue_pc),
    .issue_next_pc(issue_next_pc),
    .issue_inst(issue_inst),
    .issue_opcode(issue_opcode),
    .issue_rd(issue_rd),
    .issue_rs1(issue_rs1),
    .issue_rs2(issue_rs2),
    .issue_imm(issue_imm)
  );

  task automatic check_addr(input string what, input addr_t got, input addr_t exp);
    if (got !== exp) begin
      value_errors++;
      $display("** Error @ %0t: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_inst(input string what, input inst_t got, input inst_t exp);
    if (got !== exp) begin
      value_errors++;
      $display("** Error @ %0t: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_opcode(input string what, input opcode_e got, input opcode_e exp);
    if (got !== exp) begin
      value_errors++;
      $display("** Error @ %0t: %s is %0d, expected %s", $time, what, got, exp.name());
    end
  endtask

  task automatic check_reg(input string what, input logic [REG_W-1:0] got,
                           input logic [REG_W-1:0] exp);
    if (got !== exp) begin
      value_errors++;
      $display("** Error @ %0t: %s is x%0d, expected x%0d", $time, what, got, exp);
    end
  endtask

  task automatic check_flag(input string what, input logic got, input logic exp);
    if (got !== exp) begin
      value_errors++;
      $display("** Error @ %0t: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  // immediate by instruction format, zero where the class has none
  function automatic addr_t format_imm(input inst_t w, input opcode_e opc);
    case (opc)
      OPC_LUI, OPC_AUIPC: return {w[31:12], 12'h000};
      OPC_JAL: return {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
      OPC_JALR, OPC_LOAD, OPC_OP_IMM: return {{20{w[31]}}, w[31:20]};
      OPC_STORE: return {{20{w[31]}}, w[31:25], w[11:7]};
      OPC_BRANCH: return {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
      default: return '0;
    endcase
  endfunction

  // which of rd, rs1, rs2 the class carries
  function automatic logic [2:0] reg_fields(input opcode_e opc);
    case (opc)
      OPC_LUI, OPC_AUIPC, OPC_JAL: return 3'b100;
      OPC_JALR, OPC_LOAD, OPC_OP_IMM: return 3'b110;
      OPC_BRANCH, OPC_STORE: return 3'b011;
      OPC_OP: return 3'b111;
      default: return 3'b000;
    endcase
  endfunction

  // static rule: jal taken, backward branch taken, all else falls through
  function automatic addr_t predict_next(input addr_t pc, input inst_t w, input opcode_e opc);
    addr_t imm;
    imm = format_imm(w, opc);
    if (opc == OPC_JAL) begin
      return pc + imm;
    end
    if (opc == OPC_BRANCH && imm[31]) begin
      return pc + imm;
    end
    return pc + 32'd4;
  endfunction

  function automatic int find_row(input addr_t a);
    for (int i = 0; i < PROG_ROWS; i++) begin
      if (prog_table[i].addr == a) begin
        return i;
      end
    end
    return -1;
  endfunction

  task automatic load_program();
    for (int i = 0; i < PROG_ROWS; i++) begin
      @(negedge clk);
      prog_we = 1'b1;
      prog_addr = prog_table[i].addr;
      prog_data = prog_table[i].inst;
    end
    @(negedge clk);
    prog_we = 1'b0;
    load_busy = 1'b0;
  endtask

  // compare the issue outputs against the walked program
  task automatic sample_issue(output bit seen);
    int row;
    addr_t next_pc;
    logic [2:0] regs;
    inst_t w;
    seen = 1'b0;
    cycle_idx++;
    if (prev_full || prev_redirect) begin
      check_flag("issue_valid after a stall or redirect", issue_valid, 1'b0);
    end
    if (issue_valid === 1'b1) begin
      seen = 1'b1;
      if (issued_total == 0 && cycle_idx != MEM_LATENCY + 3) begin
        value_errors++;
        $display("** Error @ %0t: first issue after %0d cycles, expected %0d",
                 $time, cycle_idx, MEM_LATENCY + 3);
      end
      issued_total++;
      row = find_row(exp_pc);
      if (row < 0) begin
        run_errors++;
        $display("the reference model reached pc %h, which holds no program word", exp_pc);
      end else begin
        w = prog_table[row].inst;
        next_pc = predict_next(exp_pc, w, prog_table[row].opc);
        regs = reg_fields(prog_table[row].opc);
        check_addr("issue_pc", issue_pc, exp_pc);
        check_inst("issue_inst", issue_inst, w);
        check_opcode("issue_opcode", issue_opcode, prog_table[row].opc);
        check_addr("issue_next_pc", issue_next_pc, next_pc);
        check_addr("issue_imm", issue_imm, format_imm(w, prog_table[row].opc));
        if (regs[2]) begin
          check_reg("issue_rd", issue_rd, w[11:7]);
        end
        if (regs[1]) begin
          check_reg("issue_rs1", issue_rs1, w[19:15]);
        end
        if (regs[0]) begin
          check_reg("issue_rs2", issue_rs2, w[24:20]);
        end
        exp_pc = next_pc;
      end
    end
  endtask

  task automatic run_step(input step_t st);
    int cycles;
    int issued_here;
    bit seen;
    cycles = 0;
    issued_here = 0;
    while (cycles < st.min_cycles || issued_here < st.min_issues) begin
      @(negedge clk);
      sample_issue(seen);
      if (seen) begin
        issued_here++;
      end
      // the redirect is a one-cycle pulse at the start of the step
      if (cycles == 0 && st.redirect) begin
        redirect_valid = 1'b1;
        redirect_pc = st.target;
        exp_pc = st.target;
      end else begin
        redirect_valid = 1'b0;
      end
      case (st.full_mode)
        FULL_ALWAYS: is_any_full = 1'b1;
        FULL_RANDOM: is_any_full = (($urandom % 4) == 0);
        default: is_any_full = 1'b0;
      endcase
      prev_full = is_any_full;
      prev_redirect = redirect_valid;
      cycles++;
    end
  endtask

  initial begin
    cycle_count = 0;
    while (cycle_count < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycle_count++;
    end
    $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("RESULT: FAIL");
    $finish;
  end

  initial begin
    int assert_fails;
    bit seen;
    void'($urandom(32'h1d94_d6d4));
    load_busy = 1'b1;
    is_any_full = 1'b0;
    redirect_valid = 1'b0;
    redirect_pc = '0;
    prog_we = 1'b0;
    prog_addr = '0;
    prog_data = '0;
    exp_pc = '0;
    prev_full = 1'b0;
    prev_redirect = 1'b0;
    cycle_idx = 0;
    issued_total = 0;
    value_errors = 0;
    run_errors = 0;
    load_program();
    wait (!reset_from_rob_bus);
    for (int s = 0; s < NUM_STEPS; s++) begin
      run_step(step_table[s]);
    end
    @(negedge clk);
    sample_issue(seen);
    is_any_full = 1'b1;
    redirect_valid = 1'b0;
    assert_fails = u_fetch_unit_top.u_fetcher.u_assertions.fail_count;
    $display("checks done: %0d value errors, %0d run errors, %0d assertion failures, %0d issued",
             value_errors, run_errors, assert_fails, issued_total);
    if (value_errors == 0 && run_errors == 0 && assert_fails == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

//--- all.f
fetch_types_pkg.sv
rv_isa_pkg.sv
inst_fetcher.sv
line_mem_ctrl.sv
br_predictor.sv
inst_decoder.sv
fetch_unit_top.sv
fetch_unit_assertions.sv
tb_clock_gen.sv
fetch_unit_tb.sv
